// File: rtl/edge_buffer.sv
`timescale 1ns/100ps
`default_nettype none

`include "gnn_agg_defs.svh"

module edge_buffer (
    input  logic                      clk,            // core clock
    input  logic                      reset,          // sync, active high
    input  logic                      push,           // write from edge stage
    input  logic [`NODE_ID_WIDTH-1:0] push_node_id,
    input  gnn_agg_pkg::acc_vec_t     push_agg,
    input  logic                      pop,            // read from vertex stage
    output logic [`NODE_ID_WIDTH-1:0] pop_node_id,    // head entry id
    output gnn_agg_pkg::acc_vec_t     pop_agg,        // head entry aggregate
    output logic                      full,           // registered from count
    output logic                      empty           // registered from count
);

    import gnn_agg_pkg::*;

    localparam int PTR_WIDTH = $clog2(`BUF_DEPTH);
    localparam int CNT_WIDTH = $clog2(`BUF_DEPTH + 1);
    localparam logic [PTR_WIDTH-1:0] LAST_SLOT = PTR_WIDTH'(`BUF_DEPTH - 1);
    localparam logic [CNT_WIDTH-1:0] DEPTH_CNT = CNT_WIDTH'(`BUF_DEPTH);

    logic [`NODE_ID_WIDTH-1:0] node_mem [`BUF_DEPTH];    // id storage
    acc_vec_t                  agg_mem  [`BUF_DEPTH];    // aggregate storage
    logic [PTR_WIDTH-1:0]      wr_ptr;                   // next slot to write
    logic [PTR_WIDTH-1:0]      rd_ptr;                   // current head
    logic [CNT_WIDTH-1:0]      count;                    // occupancy
    logic [CNT_WIDTH-1:0]      count_d;
    logic                      wr_en;
    logic                      rd_en;

    assign wr_en = push && !full;                        // overflow write dropped
    assign rd_en = pop && !empty;                        // underflow read ignored

    always_comb begin
        case ({wr_en, rd_en})
            2'b10:   count_d = count + 1'b1;
            2'b01:   count_d = count - 1'b1;
            default: count_d = count;                    // idle or push with pop
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            full   <= 1'b0;
            empty  <= 1'b1;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;  // circular wrap
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
            end
            count <= count_d;
            full  <= (count_d == DEPTH_CNT);
            empty <= (count_d == '0);                    // head valid next cycle
        end
    end

    // storage, no reset needed for payload
    always_ff @(posedge clk) begin
        if (wr_en) begin
            node_mem[wr_ptr] <= push_node_id;
            agg_mem[wr_ptr]  <= push_agg;
        end
    end

    assign pop_node_id = node_mem[rd_ptr];               // show-ahead head
    assign pop_agg     = agg_mem[rd_ptr];

endmodule

`default_nettype wire

// File: rtl/edge_pe.sv
`timescale 1ns/100ps
`default_nettype none

`include "gnn_agg_defs.svh"

module edge_pe (
    input  logic                             clk,           // core clock
    input  logic                             reset,         // sync, active high
    input  logic                             task_valid,    // dispatch strobe
    input  logic [`NODE_ID_WIDTH-1:0]        task_node_id,  // node being aggregated
    input  logic [$clog2(`MAX_DEGREE+1)-1:0] task_degree,   // neighbor count, 0 allowed
    input  logic                             fv_valid,      // one neighbor vector per beat
    input  gnn_agg_pkg::fv_vec_t             fv_data,       // neighbor features
    input  logic                             full,          // FIFO back-pressure
    output logic                             busy,          // tells task source to wait
    output logic                             push,          // FIFO write strobe
    output logic [`NODE_ID_WIDTH-1:0]        push_node_id,  // id travelling with aggregate
    output gnn_agg_pkg::acc_vec_t            push_agg       // finished neighbor sum
);

    import gnn_agg_pkg::*;

    localparam int DEG_WIDTH = $clog2(`MAX_DEGREE + 1);
    localparam int EXT_WIDTH = `ACC_WIDTH - `FV_WIDTH;      // sign bits added per lane

    edge_state_t                state_q;                    // sequencer state
    edge_state_t                state_d;
    logic [DEG_WIDTH-1:0]       degree_q;                   // latched neighbor count
    logic [DEG_WIDTH-1:0]       beat_cnt_q;                 // beats seen so far
    logic [`NODE_ID_WIDTH-1:0]  node_id_q;                  // latched node id
    acc_vec_t                   acc_q;                      // running lane sums
    acc_vec_t                   acc_sum;                    // acc_q plus current beat
    logic                       task_accept;
    logic                       beat_accept;
    logic                       last_beat;

    assign task_accept = task_valid && (state_q == st_idle);   // only taken when idle
    assign beat_accept = fv_valid && (state_q == st_accum);
    assign last_beat   = beat_accept && (beat_cnt_q == degree_q - 1'b1); // d-th beat

    // lane-wise add, each feature sign-extended to accumulator width
    always_comb begin
        for (int lane = 0; lane < `FV_LANES; lane++) begin
            acc_sum[lane] = acc_q[lane]
                          + {{EXT_WIDTH{fv_data[lane][`FV_WIDTH-1]}}, fv_data[lane]};
        end
    end

    always_comb begin
        state_d = state_q;                                  // hold by default
        case (state_q)
            st_idle: begin
                if (task_accept) begin
                    if (task_degree == '0) begin
                        state_d = st_emit;                  // nothing to sum, zero aggregate
                    end else begin
                        state_d = st_accum;
                    end
                end
            end
            st_accum: begin
                if (last_beat) begin
                    state_d = st_emit;
                end
            end
            st_emit: begin
                if (!full) begin
                    state_d = st_idle;                      // push happens this cycle
                end
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q    <= st_idle;
            beat_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            if (task_accept) begin
                beat_cnt_q <= '0;                           // fresh count per task
            end else if (beat_accept) begin
                beat_cnt_q <= beat_cnt_q + 1'b1;
            end
        end
    end

    // task payload and lane sums
    always_ff @(posedge clk) begin
        if (task_accept) begin
            node_id_q <= task_node_id;
            degree_q  <= task_degree;
            acc_q     <= '0;                                // degree 0 leaves this as result
        end else if (beat_accept) begin
            acc_q <= acc_sum;
        end
    end

    assign busy         = (state_q != st_idle);            // high from cycle after accept
    assign push         = (state_q == st_emit) && !full;   // aggregate held while full
    assign push_node_id = node_id_q;
    assign push_agg     = acc_q;

endmodule

`default_nettype wire

// File: rtl/gnn_agg_defs.svh
`ifndef GNN_AGG_DEFS_SVH
`define GNN_AGG_DEFS_SVH

// lane geometry of one feature vector
`define FV_LANES        4       // feature lanes per vector
`define FV_WIDTH        16      // signed lane width of features

// aggregation range
`define ACC_WIDTH       20      // signed accumulator lane, 16 neighbors fit
`define MAX_DEGREE      15      // largest neighbor count, degree port is 4 bits

// task tagging
`define NODE_ID_WIDTH   8       // node id carried with every result

// vertex update arithmetic
`define WEIGHT_WIDTH    8       // signed lane weight
`define WEIGHT_FRAC     4       // product shift, weight 16 is unity gain

// rate matching between edge and vertex stage
`define BUF_DEPTH       4       // aggregate FIFO entries

`endif

// File: rtl/gnn_agg_pkg.sv
`default_nettype none

`include "gnn_agg_defs.svh"

package gnn_agg_pkg;

    // one feature lane and the full vector
    typedef logic signed [`FV_WIDTH-1:0] fv_lane_t;
    typedef fv_lane_t [`FV_LANES-1:0] fv_vec_t;         // lane 0 in the low bits

    // accumulator lanes, wide enough for a full neighbor sum
    typedef logic signed [`ACC_WIDTH-1:0] acc_lane_t;
    typedef acc_lane_t [`FV_LANES-1:0] acc_vec_t;       // aggregate carried through FIFO

    // per-lane weights of the vertex update
    typedef logic signed [`WEIGHT_WIDTH-1:0] weight_t;
    typedef weight_t [`FV_LANES-1:0] weight_vec_t;

    // edge_pe sequencer
    typedef enum logic [1:0] {
        st_idle  = 2'd0,                                // waiting for a task
        st_accum = 2'd1,                                // summing neighbor beats
        st_emit  = 2'd2                                 // holding aggregate for the FIFO
    } edge_state_t;

endpackage

`default_nettype wire

// File: rtl/gnn_agg_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "gnn_agg_defs.svh"

module gnn_agg_top (
    input  logic                             clk,           // core clock
    input  logic                             reset,         // sync, active high
    input  logic                             task_valid,    // dispatch strobe
    input  logic [`NODE_ID_WIDTH-1:0]        task_node_id,
    input  logic [$clog2(`MAX_DEGREE+1)-1:0] task_degree,
    input  logic                             fv_valid,      // neighbor beat strobe
    input  gnn_agg_pkg::fv_vec_t             fv_data,
    input  logic                             weight_load,   // weight write strobe
    input  logic [$clog2(`FV_LANES)-1:0]     weight_lane,
    input  gnn_agg_pkg::weight_t             weight_value,
    output logic                             busy,          // edge stage occupied
    output logic                             out_valid,     // result pulse
    output logic [`NODE_ID_WIDTH-1:0]        out_node_id,
    output gnn_agg_pkg::fv_vec_t             out_fv
);

    import gnn_agg_pkg::*;

    logic                      push;            // edge stage to FIFO
    logic [`NODE_ID_WIDTH-1:0] push_node_id;
    acc_vec_t                  push_agg;
    logic                      full;
    logic                      pop;             // FIFO to vertex stage
    logic [`NODE_ID_WIDTH-1:0] pop_node_id;
    acc_vec_t                  pop_agg;
    logic                      empty;

    edge_pe i_edge_pe (
        .clk          (clk),
        .reset        (reset),
        .task_valid   (task_valid),
        .task_node_id (task_node_id),
        .task_degree  (task_degree),
        .fv_valid     (fv_valid),
        .fv_data      (fv_data),
        .full         (full),
        .busy         (busy),
        .push         (push),
        .push_node_id (push_node_id),
        .push_agg     (push_agg)
    );

    edge_buffer i_edge_buffer (
        .clk          (clk),
        .reset        (reset),
        .push         (push),
        .push_node_id (push_node_id),
        .push_agg     (push_agg),
        .pop          (pop),
        .pop_node_id  (pop_node_id),
        .pop_agg      (pop_agg),
        .full         (full),
        .empty        (empty)
    );

    vertex_pe i_vertex_pe (
        .clk          (clk),
        .reset        (reset),
        .empty        (empty),
        .pop_node_id  (pop_node_id),
        .pop_agg      (pop_agg),
        .weight_load  (weight_load),
        .weight_lane  (weight_lane),
        .weight_value (weight_value),
        .pop          (pop),
        .out_valid    (out_valid),
        .out_node_id  (out_node_id),
        .out_fv       (out_fv)
    );

endmodule

`default_nettype wire

// File: rtl/vertex_pe.sv
`timescale 1ns/100ps
`default_nettype none

`include "gnn_agg_defs.svh"

module vertex_pe (
    input  logic                          clk,            // core clock
    input  logic                          reset,          // sync, active high
    input  logic                          empty,          // FIFO has no entry
    input  logic [`NODE_ID_WIDTH-1:0]     pop_node_id,    // head id
    input  gnn_agg_pkg::acc_vec_t         pop_agg,        // head aggregate
    input  logic                          weight_load,    // weight write strobe
    input  logic [$clog2(`FV_LANES)-1:0]  weight_lane,    // lane to overwrite
    input  gnn_agg_pkg::weight_t          weight_value,   // new signed weight
    output logic                          pop,            // take head entry
    output logic                          out_valid,      // one-cycle result pulse
    output logic [`NODE_ID_WIDTH-1:0]     out_node_id,
    output gnn_agg_pkg::fv_vec_t          out_fv          // updated feature vector
);

    import gnn_agg_pkg::*;

    localparam int LANE_WIDTH = $clog2(`FV_LANES);
    localparam int PROD_WIDTH = `ACC_WIDTH + `WEIGHT_WIDTH;
    localparam logic [LANE_WIDTH-1:0] LAST_LANE = LANE_WIDTH'(`FV_LANES - 1);
    localparam logic signed [PROD_WIDTH-1:0] SAT_MAX =
        {{(PROD_WIDTH - `FV_WIDTH + 1){1'b0}}, {(`FV_WIDTH - 1){1'b1}}};   // 32767

    weight_vec_t                  weights_q;        // loadable lane weights
    weight_vec_t                  work_weights_q;   // weights frozen at pop
    acc_vec_t                     work_agg_q;       // popped aggregate being processed
    logic [`NODE_ID_WIDTH-1:0]    work_node_q;
    logic [LANE_WIDTH-1:0]        lane_q;           // lane fed to the multiplier
    logic                         active_q;         // an item is in the lane loop
    logic                         lane_done;        // last lane this cycle
    acc_lane_t                    mult_a;
    weight_t                      mult_b;
    logic signed [PROD_WIDTH-1:0] product;          // full precision product
    logic signed [PROD_WIDTH-1:0] scaled;           // after fixed-point shift
    fv_lane_t                     lane_result;      // saturated and rectified

    assign lane_done = active_q && (lane_q == LAST_LANE);
    // next item may start on the edge that finishes lane 3
    assign pop       = !empty && (!active_q || lane_done);

    // one shared multiplier, lane picked by lane_q
    always_comb begin
        mult_a  = work_agg_q[lane_q];
        mult_b  = work_weights_q[lane_q];
        product = mult_a * mult_b;                  // signed 20x8
        scaled  = product >>> `WEIGHT_FRAC;         // arithmetic, keeps sign
        // clamp to 16-bit range, ReLU then zeroes anything negative
        if (scaled < 0) begin
            lane_result = '0;
        end else if (scaled > SAT_MAX) begin
            lane_result = SAT_MAX[`FV_WIDTH-1:0];
        end else begin
            lane_result = scaled[`FV_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            weights_q <= '0;                        // all lanes start at zero gain
            active_q  <= 1'b0;
            lane_q    <= '0;
            out_valid <= 1'b0;
        end else begin
            if (weight_load) begin
                weights_q[weight_lane] <= weight_value;
            end
            out_valid <= lane_done;                 // pulse after the last lane
            if (pop) begin
                active_q <= 1'b1;
                lane_q   <= '0;                     // restart at lane 0
            end else if (lane_done) begin
                active_q <= 1'b0;
                lane_q   <= '0;
            end else if (active_q) begin
                lane_q <= lane_q + 1'b1;
            end
        end
    end

    // working copy and collected result
    always_ff @(posedge clk) begin
        if (pop) begin
            work_agg_q     <= pop_agg;
            work_node_q    <= pop_node_id;
            work_weights_q <= weights_q;            // later loads hit later pops
        end
        if (active_q) begin
            out_fv[lane_q] <= lane_result;
        end
        if (lane_done) begin
            out_node_id <= work_node_q;             // old id even if pop this edge
        end
    end

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and judge by the printed result
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module gnn_agg_tb -o gnn_agg_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_output=$(./obj_dir/gnn_agg_sim 2>&1)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Regression passed" <<< "$sim_output"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: tb.f
+incdir+rtl
rtl/gnn_agg_pkg.sv
rtl/edge_pe.sv
rtl/edge_buffer.sv
rtl/vertex_pe.sv
rtl/gnn_agg_top.sv
tests/gnn_agg_properties.sv
tests/gnn_agg_tb.sv

// File: tests/gnn_agg_properties.sv
`timescale 1ns/100ps
`default_nettype none

`include "gnn_agg_defs.svh"

module gnn_agg_properties (
    input logic clk,            // core clock
    input logic reset,          // sync, active high
    input logic push,           // edge stage write into FIFO
    input logic pop,            // vertex stage read from FIFO
    input logic full,
    input logic empty,
    input logic busy,           // edge stage level
    input logic out_valid       // vertex result pulse
);

    int occupancy;              // shadow FIFO count built from push and pop

    always_ff @(posedge clk) begin
        if (reset) begin
            occupancy <= 0;
        end else begin
            occupancy <= occupancy + int'(push) - int'(pop);
        end
    end

    // FIFO protocol between the stages, judged by the shadow count
    a_no_push_full: assert property (@(posedge clk) disable iff (reset)
        push |-> occupancy < `BUF_DEPTH)
        else $error("push issued while the FIFO held %0d entries", occupancy);

    a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
        pop |-> occupancy > 0)
        else $error("pop issued while the FIFO held no entry");

    // occupancy bound and level flags
    a_occ_bound: assert property (@(posedge clk) disable iff (reset)
        occupancy >= 0 && occupancy <= `BUF_DEPTH)
        else $error("FIFO occupancy %0d outside 0 to depth", occupancy);

    a_flags_match: assert property (@(posedge clk) disable iff (reset)
        (full == (occupancy == `BUF_DEPTH)) && (empty == (occupancy == 0)))
        else $error("full or empty disagrees with occupancy %0d", occupancy);

    // lane-serial vertex stage spaces its results
    a_out_spaced: assert property (@(posedge clk) disable iff (reset) out_valid |=> !out_valid)
        else $error("out_valid high in two consecutive cycles");

    // quiet outputs coming out of reset
    a_idle_after_reset: assert property (@(posedge clk) reset |=> !busy && !out_valid)
        else $error("busy or out_valid high in the cycle after reset");

endmodule

`default_nettype wire

// File: tests/gnn_agg_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "gnn_agg_defs.svh"

module gnn_agg_tb;

    import gnn_agg_pkg::*;

    localparam int ID_WIDTH       = `NODE_ID_WIDTH;
    localparam int DEG_WIDTH      = $clog2(`MAX_DEGREE + 1);
    localparam int LANE_SEL_WIDTH = $clog2(`FV_LANES);
    localparam int SEED           = 32'h2f6a_9256;
    localparam int TIMEOUT_CYCLES = 3000;       // full run is well under a thousand cycles
    localparam int BURST_TASKS    = 24;         // enough degree-1 tasks to overrun 4 entries
    localparam longint LANE_MAX   = (longint'(1) << (`FV_WIDTH - 1)) - 1;
    localparam longint LANE_MIN   = -(longint'(1) << (`FV_WIDTH - 1));

    logic                      clk;
    logic                      reset;
    logic                      task_valid;
    logic [ID_WIDTH-1:0]       task_node_id;
    logic [DEG_WIDTH-1:0]      task_degree;
    logic                      fv_valid;
    fv_vec_t                   fv_data;
    logic                      weight_load;
    logic [LANE_SEL_WIDTH-1:0] weight_lane;
    weight_t                   weight_value;
    logic                      busy;
    logic                      out_valid;
    logic [ID_WIDTH-1:0]       out_node_id;
    fv_vec_t                   out_fv;

    int                  ref_weights [`FV_LANES];   // weights the model applies
    logic [ID_WIDTH-1:0] exp_id_q [$];              // expected results in task order
    fv_vec_t             exp_fv_q [$];
    string               current_test;
    int                  cycle_count;
    int                  mon_errors;                // errors seen by the output monitor
    int                  seq_errors;                // errors seen by the test sequence
    int                  results_checked;
    int                  busy_run;                  // consecutive busy cycles in burst test
    int                  busy_run_max;
    int                  tests_run;
    int                  test_err_start;
    int                  test_res_start;

    bind gnn_agg_top gnn_agg_properties i_properties (
        .clk       (clk),
        .reset     (reset),
        .push      (push),
        .pop       (pop),
        .full      (full),
        .empty     (empty),
        .busy      (busy),
        .out_valid (out_valid)
    );

    gnn_agg_top i_dut (
        .clk          (clk),
        .reset        (reset),
        .task_valid   (task_valid),
        .task_node_id (task_node_id),
        .task_degree  (task_degree),
        .fv_valid     (fv_valid),
        .fv_data      (fv_data),
        .weight_load  (weight_load),
        .weight_lane  (weight_lane),
        .weight_value (weight_value),
        .busy         (busy),
        .out_valid    (out_valid),
        .out_node_id  (out_node_id),
        .out_fv       (out_fv)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                      // 8 ns period
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("ERROR: timeout after %0d cycles, test %s hung", cycle_count, current_test);
            $display("Regression failed");
            $finish;
        end
    end

    // sum of lanes times weight, fixed-point shift, 16-bit clamp, then ReLU
    function automatic fv_lane_t update_lane(input longint sum, input int weight);
        longint scaled;
        scaled = (sum * longint'(weight)) >>> `WEIGHT_FRAC;
        if (scaled > LANE_MAX) begin
            scaled = LANE_MAX;
        end else if (scaled < LANE_MIN) begin
            scaled = LANE_MIN;
        end
        if (scaled < 0) begin
            scaled = 0;
        end
        return fv_lane_t'(scaled);
    endfunction

    task automatic check_result();
        logic [ID_WIDTH-1:0] exp_id;
        fv_vec_t             exp_fv;
        results_checked++;
        assert (exp_id_q.size() != 0) else begin
            $display("ERROR: %s: result for node %0d with no task pending", current_test,
                     out_node_id);
            mon_errors++;
        end
        if (exp_id_q.size() != 0) begin
            exp_id = exp_id_q.pop_front();
            exp_fv = exp_fv_q.pop_front();
            assert (out_node_id === exp_id) else begin
                $display("[FAIL] %s: node id expected %0d actual %0d", current_test, exp_id,
                         out_node_id);
                mon_errors++;
            end
            for (int lane = 0; lane < `FV_LANES; lane++) begin
                assert (out_fv[lane] === exp_fv[lane]) else begin
                    $display("[FAIL] %s: node %0d lane %0d expected %0d actual %0d",
                             current_test, exp_id, lane, exp_fv[lane], out_fv[lane]);
                    mon_errors++;
                end
            end
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            if (out_valid) begin
                check_result();
            end
            if (busy && current_test == "burst_backpressure") begin
                busy_run++;
                if (busy_run > busy_run_max) begin
                    busy_run_max = busy_run;
                end
            end else begin
                busy_run = 0;
            end
        end
    end

    task automatic load_weights(input int w0, input int w1, input int w2, input int w3);
        int w [`FV_LANES];
        w[0] = w0;
        w[1] = w1;
        w[2] = w2;
        w[3] = w3;
        for (int lane = 0; lane < `FV_LANES; lane++) begin
            weight_load       = 1'b1;
            weight_lane       = LANE_SEL_WIDTH'(lane);
            weight_value      = weight_t'(w[lane]);
            ref_weights[lane] = w[lane];
            @(negedge clk);
        end
        weight_load = 1'b0;
    endtask

    // waits for busy low, dispatches, then streams beats with random gaps
    task automatic run_task(input int node, input int degree, input int max_gap,
                            input bit big_lane0);
        fv_vec_t   beat;
        fv_vec_t   expected;
        fv_lane_t  lane_val;
        longint    sums [`FV_LANES];
        int        gap;
        for (int lane = 0; lane < `FV_LANES; lane++) begin
            sums[lane] = 0;
        end
        while (busy) begin
            @(negedge clk);
        end
        task_valid   = 1'b1;
        task_node_id = ID_WIDTH'(node);
        task_degree  = DEG_WIDTH'(degree);
        @(negedge clk);
        task_valid = 1'b0;
        for (int b = 0; b < degree; b++) begin
            gap = $urandom_range(0, max_gap);
            repeat (gap) @(negedge clk);
            for (int lane = 0; lane < `FV_LANES; lane++) begin
                lane_val   = (big_lane0 && lane == 0) ? 16'sd30000 : fv_lane_t'($urandom());
                beat[lane] = lane_val;
                sums[lane] += lane_val;
            end
            fv_valid = 1'b1;
            fv_data  = beat;
            @(negedge clk);
            fv_valid = 1'b0;
        end
        for (int lane = 0; lane < `FV_LANES; lane++) begin
            expected[lane] = update_lane(sums[lane], ref_weights[lane]);
        end
        exp_id_q.push_back(ID_WIDTH'(node));
        exp_fv_q.push_back(expected);
    endtask

    task automatic wait_drain();
        while (exp_id_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (6) @(negedge clk);                  // room for any stray result
    endtask

    task automatic start_test(input string name);
        current_test   = name;
        test_err_start = mon_errors + seq_errors;
        test_res_start = results_checked;
    endtask

    task automatic finish_test();
        tests_run++;
        $display("test %0d %s: %0d results checked, %0d errors", tests_run, current_test,
                 results_checked - test_res_start, mon_errors + seq_errors - test_err_start);
    endtask

    initial begin
        reset        = 1'b1;
        task_valid   = 1'b0;
        task_node_id = '0;
        task_degree  = '0;
        fv_valid     = 1'b0;
        fv_data      = '0;
        weight_load  = 1'b0;
        weight_lane  = '0;
        weight_value = '0;
        current_test = "reset";
        void'($urandom(SEED));
        for (int lane = 0; lane < `FV_LANES; lane++) begin
            ref_weights[lane] = 0;                  // DUT weights clear on reset
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        start_test("reset_idle");
        repeat (20) begin
            @(negedge clk);
            assert (!busy && !out_valid) else begin
                $display("ERROR: %s: busy or out_valid high with no task issued", current_test);
                seq_errors++;
            end
        end
        finish_test();

        start_test("single_neighbor");
        load_weights(16, 16, 16, 16);               // unity gain
        for (int i = 0; i < 8; i++) begin
            run_task(8'h01 + i, 1, 2, 1'b0);
        end
        wait_drain();
        finish_test();

        start_test("multi_neighbor");
        run_task(8'h20, 5, 1, 1'b1);                // lane 0 sums to 150000
        for (int i = 0; i < 10; i++) begin
            run_task(8'h21 + i, $urandom_range(1, `MAX_DEGREE), 3, 1'b0);
        end
        wait_drain();
        finish_test();

        start_test("zero_degree");
        run_task(8'h30, 0, 0, 1'b0);
        run_task(8'h31, 2, 1, 1'b0);
        run_task(8'h32, 0, 0, 1'b0);
        wait_drain();
        finish_test();

        start_test("burst_backpressure");
        for (int i = 0; i < BURST_TASKS; i++) begin
            run_task(8'h40 + i, 1, 0, 1'b0);
        end
        wait_drain();
        // an unblocked degree-1 task keeps busy for two cycles
        assert (busy_run_max >= 3) else begin
            $display("ERROR: %s: busy never held high by a full buffer", current_test);
            seq_errors++;
        end
        finish_test();

        start_test("weight_reload");
        load_weights(-16, 32, 8, -4);
        for (int i = 0; i < 4; i++) begin
            run_task(8'h60 + i, $urandom_range(1, 6), 1, 1'b0);
        end
        wait_drain();
        load_weights(16, -8, 64, 127);
        for (int i = 0; i < 4; i++) begin
            run_task(8'h70 + i, $urandom_range(1, 6), 1, 1'b0);
        end
        wait_drain();
        finish_test();

        $display("totals: %0d tests, %0d results checked, %0d errors", tests_run,
                 results_checked, mon_errors + seq_errors);
        if (mon_errors + seq_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
